/* cache_ctrl.sv */
// Command FSM; one command in flight, strobes while busy_o is high are dropped
`default_nettype none

`include "split_cache_config.svh"

module cache_ctrl
    import split_cache_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        cmd_valid_i,
    input  opcode_e                     cmd_op_i,
    input  addr_u                       cmd_addr_i,
    // Data side lookup results
    input  logic                        d_hit_i,
    input  logic [D_WAY_W-1:0]          d_hit_way_i,
    input  logic [D_WAY_W-1:0]          d_victim_way_i,
    input  mesi_e                       d_victim_mesi_i,
    input  tag_t  [`D_WAYS-1:0]         d_line_tag_i,
    input  mesi_e [`D_WAYS-1:0]         d_line_mesi_i,
    input  age_t  [`D_WAYS-1:0]         d_line_age_i,
    input  age_t  [`D_WAYS-1:0]         d_lru_age_i,
    // Instruction side lookup results
    input  logic                        i_hit_i,
    input  logic [I_WAY_W-1:0]          i_hit_way_i,
    input  logic [I_WAY_W-1:0]          i_victim_way_i,
    input  tag_t  [`I_WAYS-1:0]         i_line_tag_i,
    input  mesi_e [`I_WAYS-1:0]         i_line_mesi_i,
    input  age_t  [`I_WAYS-1:0]         i_lru_age_i,
    // Store control
    output logic                        d_rd_en_o,
    output logic                        i_rd_en_o,
    output logic                        d_wr_en_o,
    output logic                        i_wr_en_o,
    output logic                        clr_o,
    output logic [D_SET_W-1:0]          d_set_o,
    output logic [I_SET_W-1:0]          i_set_o,
    output tag_t                        d_tag_o,
    output tag_t                        i_tag_o,
    output tag_t  [`D_WAYS-1:0]         d_tag_wr_o,
    output mesi_e [`D_WAYS-1:0]         d_mesi_wr_o,
    output age_t  [`D_WAYS-1:0]         d_age_wr_o,
    output tag_t  [`I_WAYS-1:0]         i_tag_wr_o,
    output mesi_e [`I_WAYS-1:0]         i_mesi_wr_o,
    output age_t  [`I_WAYS-1:0]         i_age_wr_o,
    // LRU control, shared by both sides
    output logic [D_WAY_W-1:0]          d_lru_way_o,
    output logic [I_WAY_W-1:0]          i_lru_way_o,
    output logic                        replace_o,
    // Responses
    output logic                        resp_valid_o,
    output logic                        hit_o,
    output logic [D_WAY_W-1:0]          way_o,
    output mesi_e                       mesi_o,
    output logic                        writeback_o,
    output logic                        busy_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_CLEAR
    } state_e;

    state_e               state_q;
    logic [D_SET_W-1:0]   clr_cnt_q;
    // Latched command
    opcode_e              op_q;
    addr_u                addr_q;

    logic                 lookup_op;
    logic                 accept;
    logic                 is_fetch;
    logic                 hit_sel;
    logic [D_WAY_W-1:0]   sel_way;
    mesi_e                cur_mesi;
    mesi_e                new_mesi;
    logic                 wb;

    assign lookup_op = cmd_op_i inside {OP_READ, OP_WRITE, OP_FETCH, OP_INVAL};
    assign accept    = state_q == S_IDLE && cmd_valid_i;
    assign busy_o    = state_q != S_IDLE;

    // Only the side the opcode needs is read
    assign d_rd_en_o = accept && lookup_op && cmd_op_i != OP_FETCH;
    assign i_rd_en_o = accept && cmd_op_i == OP_FETCH;
    assign clr_o     = state_q == S_CLEAR;

    // Set index comes from the strobe in idle so the read lands at the same edge
    always_comb begin
        case (state_q)
            S_CLEAR: begin
                d_set_o = clr_cnt_q;
                i_set_o = {clr_cnt_q, (I_SET_W - D_SET_W)'(0)};
            end
            S_LOOKUP: begin
                d_set_o = addr_q.d.set;
                i_set_o = addr_q.i.set;
            end
            default: begin
                d_set_o = cmd_addr_i.d.set;
                i_set_o = cmd_addr_i.i.set;
            end
        endcase
    end

    assign d_tag_o = addr_q.d.tag;
    assign i_tag_o = tag_t'(addr_q.i.tag);

    // Pick the side, then the hit way or the victim
    assign is_fetch = op_q == OP_FETCH;
    assign hit_sel  = is_fetch ? i_hit_i : d_hit_i;

    always_comb begin
        if (is_fetch) begin
            sel_way  = D_WAY_W'(hit_sel ? i_hit_way_i : i_victim_way_i);
            cur_mesi = i_line_mesi_i[sel_way[I_WAY_W-1:0]];
        end else begin
            sel_way  = hit_sel ? d_hit_way_i : d_victim_way_i;
            cur_mesi = d_line_mesi_i[sel_way];
        end
    end

    // MESI rules
    always_comb begin
        case (op_q)
            OP_READ:  new_mesi = hit_sel ? cur_mesi : MESI_E;
            OP_WRITE: new_mesi = MESI_M;
            OP_FETCH: new_mesi = hit_sel ? cur_mesi : MESI_S;
            default:  new_mesi = MESI_I;
        endcase
    end

    // Dirty victim on a data fill
    assign wb = !hit_sel && (op_q == OP_READ || op_q == OP_WRITE) && d_victim_mesi_i == MESI_M;

    // Invalidate miss leaves the set untouched
    assign d_wr_en_o = state_q == S_LOOKUP && !is_fetch && (hit_sel || op_q != OP_INVAL);
    assign i_wr_en_o = state_q == S_LOOKUP && is_fetch;

    assign d_lru_way_o = sel_way;
    assign i_lru_way_o = sel_way[I_WAY_W-1:0];
    assign replace_o   = !hit_sel;

    // Written set is the read set with the touched way patched
    always_comb begin
        d_tag_wr_o                             = d_line_tag_i;
        d_mesi_wr_o                            = d_line_mesi_i;
        d_tag_wr_o[sel_way]                    = d_tag_o;
        d_mesi_wr_o[sel_way]                   = new_mesi;
        i_tag_wr_o                             = i_line_tag_i;
        i_mesi_wr_o                            = i_line_mesi_i;
        i_tag_wr_o[sel_way[I_WAY_W-1:0]]       = i_tag_o;
        i_mesi_wr_o[sel_way[I_WAY_W-1:0]]      = new_mesi;
    end

    // Invalidate keeps ages as they were
    assign d_age_wr_o = op_q == OP_INVAL ? d_line_age_i : d_lru_age_i;
    assign i_age_wr_o = i_lru_age_i;

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= cmd_op_i;
            addr_q <= cmd_addr_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= S_IDLE;
            clr_cnt_q    <= '0;
            resp_valid_o <= 1'b0;
            hit_o        <= 1'b0;
            way_o        <= '0;
            mesi_o       <= MESI_I;
            writeback_o  <= 1'b0;
        end else begin
            resp_valid_o <= 1'b0;
            writeback_o  <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (accept && lookup_op) begin
                        state_q <= S_LOOKUP;
                    end else if (accept && cmd_op_i == OP_CLEAR) begin
                        state_q   <= S_CLEAR;
                        clr_cnt_q <= '0;
                    end
                end
                S_LOOKUP: begin
                    // Set write and response share this edge
                    state_q      <= S_IDLE;
                    resp_valid_o <= 1'b1;
                    hit_o        <= hit_sel;
                    way_o        <= sel_way;
                    mesi_o       <= new_mesi;
                    writeback_o  <= wb;
                end
                S_CLEAR: begin
                    clr_cnt_q <= clr_cnt_q + 1'b1;
                    if (clr_cnt_q == D_SET_W'(`D_SETS - 1)) begin
                        // Sweep done, answer with nothing to report
                        state_q      <= S_IDLE;
                        resp_valid_o <= 1'b1;
                        hit_o        <= 1'b0;
                        way_o        <= '0;
                        mesi_o       <= MESI_I;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* lru_update.sv */
// Age update for one set; invalid ways keep their age, ages saturate at the LRU_W maximum
`default_nettype none

`include "split_cache_config.svh"

module lru_update
    import split_cache_pkg::*;
#(
    parameter int  WAYS  = `D_WAYS,
    localparam int WAY_W = $clog2(WAYS)
) (
    input  age_t  [WAYS-1:0]    age_i,
    input  mesi_e [WAYS-1:0]    mesi_i,
    input  logic [WAY_W-1:0]    way_i,
    input  logic                replace_i,
    output age_t  [WAYS-1:0]    age_o
);

    // Old age of the touched way, a replaced victim counts as oldest
    age_t touch_age;

    always_comb begin
        touch_age = replace_i ? '1 : age_i[way_i];
        for (int w = 0; w < WAYS; w++) begin
            age_o[w] = age_i[w];
            if (WAY_W'(w) == way_i) begin
                // Touched way becomes most recent
                age_o[w] = '0;
            end else if (mesi_i[w] != MESI_I && age_i[w] < touch_age) begin
                // Below touch_age means below max, so no wrap
                age_o[w] = age_i[w] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* split_cache_checker.sv */
// Protocol assertions on cache_ctrl; op_q and addr_q stay X until the first accepted strobe
`default_nettype none

module split_cache_checker
    import split_cache_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    cmd_valid_i,
    input  opcode_e cmd_op_i,
    input  logic    busy_i,
    input  logic    clr_i,
    input  logic    resp_valid_i,
    input  logic    writeback_i,
    input  opcode_e op_q_i,
    input  addr_u   addr_q_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // One counter per property
    int latency_fail_cnt = 0;
    int orphan_fail_cnt  = 0;
    int drop_fail_cnt    = 0;

    logic accept_lookup;

    // Accepted strobe with one of the four lookup opcodes
    assign accept_lookup = cmd_valid_i && !busy_i
                           && cmd_op_i inside {OP_READ, OP_WRITE, OP_FETCH, OP_INVAL};

    // Answer lands exactly two edges after the strobe
    resp_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        accept_lookup |-> ##1 !resp_valid_i ##1 resp_valid_i)
        else begin
            $error("lookup response not two cycles after the strobe");
            latency_fail_cnt++;
        end

    // A response or a writeback needs a command that was in flight
    resp_pending: assert property (@(posedge clk) disable iff (!rst_n_i)
        (resp_valid_i || writeback_i) |-> $past(busy_i))
        else begin
            $error("response or writeback without a pending command");
            orphan_fail_cnt++;
        end

    // Dropped strobe leaves the latched command alone and does not stretch a lookup
    busy_drop: assert property (@(posedge clk) disable iff (!rst_n_i)
        cmd_valid_i && busy_i |=> $stable(op_q_i) && $stable(addr_q_i)
                                  && ($past(clr_i) || !busy_i))
        else begin
            $error("strobe while busy was taken");
            drop_fail_cnt++;
        end

endmodule

bind cache_ctrl split_cache_checker i_split_cache_checker (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_op_i     (cmd_op_i),
    .busy_i       (busy_o),
    .clr_i        (clr_o),
    .resp_valid_i (resp_valid_o),
    .writeback_i  (writeback_o),
    .op_q_i       (op_q),
    .addr_q_i     (addr_q)
);

`default_nettype wire

/* split_cache_config.svh */
// Sizes of the split L1 tag model; I_SETS must be a multiple of D_SETS for the clear sweep
`ifndef SPLIT_CACHE_CONFIG_SVH
`define SPLIT_CACHE_CONFIG_SVH

// Associativity of each side
`define D_WAYS 8
`define I_WAYS 4

// Number of sets per side
// Instruction side has twice the sets so its tag is one bit shorter
`define D_SETS 16
`define I_SETS 32

// Command address width
`define ADDR_W 16

// Byte offset bits inside a line, shared by both views
`define OFF_W 2

// LRU age width, 0 is most recent
`define LRU_W 3

`endif

/* split_cache_pkg.sv */
// Types for the split L1 tag model; instruction tags are zero-extended to the data tag width
`default_nettype none

`include "split_cache_config.svh"

package split_cache_pkg;

    // Field widths derived from the config sizes
    localparam int D_SET_W = $clog2(`D_SETS);
    localparam int I_SET_W = $clog2(`I_SETS);
    localparam int D_TAG_W = `ADDR_W - D_SET_W - `OFF_W;
    localparam int I_TAG_W = `ADDR_W - I_SET_W - `OFF_W;
    localparam int D_WAY_W = $clog2(`D_WAYS);
    localparam int I_WAY_W = $clog2(`I_WAYS);

    // Stored line fields, one tag width for both stores
    typedef logic [D_TAG_W-1:0] tag_t;
    typedef logic [`LRU_W-1:0]  age_t;

    typedef enum logic [1:0] {
        MESI_I = 2'b00,
        MESI_S = 2'b01,
        MESI_E = 2'b10,
        MESI_M = 2'b11
    } mesi_e;

    // Trace opcodes, 9 (print) is not handled
    typedef enum logic [3:0] {
        OP_READ  = 4'd0,
        OP_WRITE = 4'd1,
        OP_FETCH = 4'd2,
        OP_INVAL = 4'd3,
        OP_CLEAR = 4'd8
    } opcode_e;

    // Data side split of an address
    typedef struct packed {
        logic [D_TAG_W-1:0] tag;
        logic [D_SET_W-1:0] set;
        logic [`OFF_W-1:0]  off;
    } d_addr_t;

    // Instruction side split of the same word
    typedef struct packed {
        logic [I_TAG_W-1:0] tag;
        logic [I_SET_W-1:0] set;
        logic [`OFF_W-1:0]  off;
    } i_addr_t;

    // One address word, decoded per side
    typedef union packed {
        d_addr_t d;
        i_addr_t i;
    } addr_u;

endpackage

`default_nettype wire

/* split_cache_tb.sv */
// Trace-driven; expects split_cache_trace.txt in the project root, strobes only when idle
`default_nettype none

module split_cache_tb
    import split_cache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TRACE_MAX = 64;
    localparam int FIELDS    = 6;
    localparam int TIMEOUT   = 40;

    logic                clk;
    logic                rst_n_i;
    logic                cmd_valid_i;
    opcode_e             cmd_op_i;
    addr_u               cmd_addr_i;
    logic                resp_valid_o;
    logic                hit_o;
    logic [D_WAY_W-1:0]  way_o;
    mesi_e               mesi_o;
    logic                writeback_o;
    logic                busy_o;

    // Six words per trace entry
    logic [15:0] trace_mem [TRACE_MAX*FIELDS];

    int check_cnt;
    int error_cnt;
    int fault_cnt;
    int assert_cnt;

    split_cache_top i_split_cache_top (
        .clk, .rst_n_i, .cmd_valid_i, .cmd_op_i, .cmd_addr_i,
        .resp_valid_o, .hit_o, .way_o, .mesi_o, .writeback_o, .busy_o
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        check_cnt++;
        if (actual !== expected) begin
            error_cnt++;
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // Both waits step on falling edges, where outputs are settled
    task automatic wait_idle(output bit ok);
        int cycles;
        cycles = 0;
        while (busy_o !== 1'b0 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        ok = busy_o === 1'b0;
    endtask

    task automatic wait_response(output bit ok);
        int cycles;
        cycles = 0;
        while (resp_valid_o !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        ok = resp_valid_o === 1'b1;
    endtask

    // One strobe, then compare the answer with the trace columns
    task automatic apply_entry(input int idx, output bit ok);
        int    base;
        string name;
        base = idx * FIELDS;
        name = $sformatf("entry %0d op %0h addr %04h", idx, trace_mem[base][3:0],
                         trace_mem[base+1]);
        @(negedge clk);
        wait_idle(ok);
        if (!ok) begin
            $display("Controller stayed busy before %s", name);
        end else begin
            cmd_valid_i = 1'b1;
            cmd_op_i    = opcode_e'(trace_mem[base][3:0]);
            cmd_addr_i  = trace_mem[base+1];
            @(negedge clk);
            cmd_valid_i = 1'b0;
            wait_response(ok);
            if (!ok) begin
                $display("No response for %s", name);
            end else begin
                check_value({name, " hit"}, trace_mem[base+2], hit_o);
                // Way and MESI are skipped where the trace holds f
                if (trace_mem[base+3] != 16'h000f) begin
                    check_value({name, " way"}, trace_mem[base+3], way_o);
                end
                if (trace_mem[base+4] != 16'h000f) begin
                    check_value({name, " mesi"}, trace_mem[base+4], mesi_o);
                end
                check_value({name, " writeback"}, trace_mem[base+5], writeback_o);
            end
        end
    endtask

    initial begin
        bit ok;
        int idx;
        check_cnt   = 0;
        error_cnt   = 0;
        fault_cnt   = 0;
        rst_n_i     = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_op_i    = OP_READ;
        cmd_addr_i  = '0;
        $readmemh("split_cache_trace.txt", trace_mem);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        // Outputs quiet out of reset
        check_value("reset resp_valid", 16'h0, resp_valid_o);
        check_value("reset busy", 16'h0, busy_o);
        check_value("reset writeback", 16'h0, writeback_o);
        if ($isunknown(trace_mem[0])) begin
            $display("Trace file is missing or empty");
            fault_cnt++;
        end
        ok  = 1'b1;
        idx = 0;
        while (ok && idx < TRACE_MAX && !$isunknown(trace_mem[idx*FIELDS])
               && trace_mem[idx*FIELDS] != 16'h000f) begin
            apply_entry(idx, ok);
            if (!ok) begin
                fault_cnt++;
            end
            idx++;
        end
        assert_cnt = i_split_cache_top.i_cache_ctrl.i_split_cache_checker.latency_fail_cnt
                   + i_split_cache_top.i_cache_ctrl.i_split_cache_checker.orphan_fail_cnt
                   + i_split_cache_top.i_cache_ctrl.i_split_cache_checker.drop_fail_cnt;
        $display("%0d entries, %0d checks, %0d mismatches, %0d faults, %0d assertion errors",
                 idx, check_cnt, error_cnt, fault_cnt, assert_cnt);
        if (error_cnt == 0 && fault_cnt == 0 && assert_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* split_cache_top.sv */
// Split L1 tag/state model; 2-cycle lookups, clear takes D_SETS+1 cycles, no back-pressure
`default_nettype none

`include "split_cache_config.svh"

module split_cache_top
    import split_cache_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                cmd_valid_i,
    input  opcode_e             cmd_op_i,
    input  addr_u               cmd_addr_i,
    output logic                resp_valid_o,
    output logic                hit_o,
    output logic [D_WAY_W-1:0]  way_o,
    output mesi_e               mesi_o,
    output logic                writeback_o,
    output logic                busy_o
);

    // Data side nets
    logic                   d_rd_en, d_wr_en, d_hit;
    logic [D_SET_W-1:0]     d_set;
    tag_t                   d_tag;
    logic [D_WAY_W-1:0]     d_hit_way, d_victim_way, d_lru_way;
    mesi_e                  d_victim_mesi;
    tag_t  [`D_WAYS-1:0]    d_line_tag, d_tag_wr;
    mesi_e [`D_WAYS-1:0]    d_line_mesi, d_mesi_wr;
    age_t  [`D_WAYS-1:0]    d_line_age, d_age_wr, d_lru_age;

    // Instruction side nets
    logic                   i_rd_en, i_wr_en, i_hit;
    logic [I_SET_W-1:0]     i_set;
    tag_t                   i_tag;
    logic [I_WAY_W-1:0]     i_hit_way, i_victim_way, i_lru_way;
    tag_t  [`I_WAYS-1:0]    i_line_tag, i_tag_wr;
    mesi_e [`I_WAYS-1:0]    i_line_mesi, i_mesi_wr;
    age_t  [`I_WAYS-1:0]    i_line_age, i_age_wr, i_lru_age;

    logic                   clr, replace;

    cache_ctrl i_cache_ctrl (
        .clk, .rst_n_i, .cmd_valid_i, .cmd_op_i, .cmd_addr_i,
        .d_hit_i(d_hit), .d_hit_way_i(d_hit_way), .d_victim_way_i(d_victim_way),
        .d_victim_mesi_i(d_victim_mesi), .d_line_tag_i(d_line_tag),
        .d_line_mesi_i(d_line_mesi), .d_line_age_i(d_line_age), .d_lru_age_i(d_lru_age),
        .i_hit_i(i_hit), .i_hit_way_i(i_hit_way), .i_victim_way_i(i_victim_way),
        .i_line_tag_i(i_line_tag), .i_line_mesi_i(i_line_mesi), .i_lru_age_i(i_lru_age),
        .d_rd_en_o(d_rd_en), .i_rd_en_o(i_rd_en), .d_wr_en_o(d_wr_en), .i_wr_en_o(i_wr_en),
        .clr_o(clr), .d_set_o(d_set), .i_set_o(i_set), .d_tag_o(d_tag), .i_tag_o(i_tag),
        .d_tag_wr_o(d_tag_wr), .d_mesi_wr_o(d_mesi_wr), .d_age_wr_o(d_age_wr),
        .i_tag_wr_o(i_tag_wr), .i_mesi_wr_o(i_mesi_wr), .i_age_wr_o(i_age_wr),
        .d_lru_way_o(d_lru_way), .i_lru_way_o(i_lru_way), .replace_o(replace),
        .resp_valid_o, .hit_o, .way_o, .mesi_o, .writeback_o, .busy_o
    );

    tag_store #(.WAYS(`D_WAYS), .SETS(`D_SETS)) i_d_tag_store (
        .clk, .rst_n_i, .rd_en_i(d_rd_en), .set_i(d_set), .wr_en_i(d_wr_en), .clr_i(clr),
        .tag_wr_i(d_tag_wr), .mesi_wr_i(d_mesi_wr), .age_wr_i(d_age_wr),
        .tag_o(d_line_tag), .mesi_o(d_line_mesi), .age_o(d_line_age)
    );

    tag_store #(.WAYS(`I_WAYS), .SETS(`I_SETS)) i_i_tag_store (
        .clk, .rst_n_i, .rd_en_i(i_rd_en), .set_i(i_set), .wr_en_i(i_wr_en), .clr_i(clr),
        .tag_wr_i(i_tag_wr), .mesi_wr_i(i_mesi_wr), .age_wr_i(i_age_wr),
        .tag_o(i_line_tag), .mesi_o(i_line_mesi), .age_o(i_line_age)
    );

    way_lookup #(.WAYS(`D_WAYS)) i_d_way_lookup (
        .tag_i(d_tag), .line_tag_i(d_line_tag), .line_mesi_i(d_line_mesi),
        .line_age_i(d_line_age), .hit_o(d_hit), .hit_way_o(d_hit_way),
        .victim_way_o(d_victim_way), .victim_mesi_o(d_victim_mesi)
    );

    // Instruction victims are never Modified
    way_lookup #(.WAYS(`I_WAYS)) i_i_way_lookup (
        .tag_i(i_tag), .line_tag_i(i_line_tag), .line_mesi_i(i_line_mesi),
        .line_age_i(i_line_age), .hit_o(i_hit), .hit_way_o(i_hit_way),
        .victim_way_o(i_victim_way), .victim_mesi_o()
    );

    lru_update #(.WAYS(`D_WAYS)) i_d_lru_update (
        .age_i(d_line_age), .mesi_i(d_line_mesi), .way_i(d_lru_way),
        .replace_i(replace), .age_o(d_lru_age)
    );

    lru_update #(.WAYS(`I_WAYS)) i_i_lru_update (
        .age_i(i_line_age), .mesi_i(i_line_mesi), .way_i(i_lru_way),
        .replace_i(replace), .age_o(i_lru_age)
    );

endmodule

`default_nettype wire

/* split_cache_trace.txt */
// Columns: opcode address hit way mesi writeback, all hex, mesi 0=I 1=S 2=E 3=M
// An f in the way or mesi column skips that compare, opcode f ends the trace
0 0004 0 0 2 0
0 0044 0 1 2 0
0 0084 0 2 2 0
0 0044 1 1 2 0
1 0044 1 1 3 0
0 00c4 0 3 2 0
0 0104 0 4 2 0
0 0144 0 5 2 0
0 0184 0 6 2 0
0 01c4 0 7 2 0
0 0204 0 0 2 0
0 0244 0 2 2 0
0 0284 0 1 2 1
1 0004 0 3 3 0
2 0204 0 0 1 0
2 0204 1 0 1 0
0 0204 1 0 2 0
2 0004 0 1 1 0
2 0084 0 2 1 0
2 0104 0 3 1 0
2 0184 0 0 1 0
2 0204 0 1 1 0
3 0144 1 5 0 0
3 0044 0 f f 0
0 02c4 0 5 2 0
8 0000 0 f f 0
0 0204 0 0 2 0
2 0184 0 0 1 0
0 0284 0 1 2 0
f 0000 0 0 0 0

/* tag_store.sv */
// Per-set tag/MESI/age array; read data lags rd_en_i by one cycle, clear wins over write
`default_nettype none

`include "split_cache_config.svh"

module tag_store
    import split_cache_pkg::*;
#(
    parameter int  WAYS  = `D_WAYS,
    parameter int  SETS  = `D_SETS,
    localparam int SET_W = $clog2(SETS),
    // Sets wiped per clear cycle, the sweep runs D_SETS cycles on both sides
    localparam int CLR_N = SETS / `D_SETS
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    rd_en_i,
    input  logic [SET_W-1:0]        set_i,
    input  logic                    wr_en_i,
    input  logic                    clr_i,
    input  tag_t  [WAYS-1:0]        tag_wr_i,
    input  mesi_e [WAYS-1:0]        mesi_wr_i,
    input  age_t  [WAYS-1:0]        age_wr_i,
    output tag_t  [WAYS-1:0]        tag_o,
    output mesi_e [WAYS-1:0]        mesi_o,
    output age_t  [WAYS-1:0]        age_o
);

    // Whole array, one packed row per set
    tag_t  [WAYS-1:0] tag_q  [SETS];
    mesi_e [WAYS-1:0] mesi_q [SETS];
    age_t  [WAYS-1:0] age_q  [SETS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    tag_q[s][w]  <= '0;
                    mesi_q[s][w] <= MESI_I;
                    age_q[s][w]  <= '0;
                end
            end
        end else if (clr_i) begin
            // set_i points at the first set of the group
            for (int k = 0; k < CLR_N; k++) begin
                for (int w = 0; w < WAYS; w++) begin
                    mesi_q[set_i + SET_W'(k)][w] <= MESI_I;
                    age_q[set_i + SET_W'(k)][w]  <= '0;
                end
            end
        end else if (wr_en_i) begin
            // Whole-set write back from the controller
            tag_q[set_i]  <= tag_wr_i;
            mesi_q[set_i] <= mesi_wr_i;
            age_q[set_i]  <= age_wr_i;
        end
    end

    // Registered set read, held until the next read
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            tag_o  <= tag_q[set_i];
            mesi_o <= mesi_q[set_i];
            age_o  <= age_q[set_i];
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
split_cache_pkg.sv
tag_store.sv
way_lookup.sv
lru_update.sv
cache_ctrl.sv
split_cache_top.sv
split_cache_checker.sv
split_cache_tb.sv

/* way_lookup.sv */
// Tag compare and victim pick for one set; purely combinational, ties go to the lowest way
`default_nettype none

`include "split_cache_config.svh"

module way_lookup
    import split_cache_pkg::*;
#(
    parameter int  WAYS  = `D_WAYS,
    localparam int WAY_W = $clog2(WAYS)
) (
    input  tag_t                tag_i,
    input  tag_t  [WAYS-1:0]    line_tag_i,
    input  mesi_e [WAYS-1:0]    line_mesi_i,
    input  age_t  [WAYS-1:0]    line_age_i,
    output logic                hit_o,
    output logic [WAY_W-1:0]    hit_way_o,
    output logic [WAY_W-1:0]    victim_way_o,
    output mesi_e               victim_mesi_o
);

    // Oldest invalid way so far
    logic             any_inv;
    logic [WAY_W-1:0] inv_way;
    age_t             inv_age;
    // Oldest way overall
    logic [WAY_W-1:0] old_way;
    age_t             old_age;

    // Hit needs a valid way with the same tag
    always_comb begin
        hit_o     = 1'b0;
        hit_way_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (!hit_o && line_mesi_i[w] != MESI_I && line_tag_i[w] == tag_i) begin
                hit_o     = 1'b1;
                hit_way_o = WAY_W'(w);
            end
        end
    end

    // Victim scan, strict compares keep the lower index on a tie
    always_comb begin
        any_inv = 1'b0;
        inv_way = '0;
        inv_age = '0;
        old_way = '0;
        old_age = line_age_i[0];
        for (int w = 0; w < WAYS; w++) begin
            if (line_mesi_i[w] == MESI_I && (!any_inv || line_age_i[w] > inv_age)) begin
                any_inv = 1'b1;
                inv_way = WAY_W'(w);
                inv_age = line_age_i[w];
            end
            if (line_age_i[w] > old_age) begin
                old_way = WAY_W'(w);
                old_age = line_age_i[w];
            end
        end
        // Invalid ways are always used before evicting a live line
        victim_way_o  = any_inv ? inv_way : old_way;
        victim_mesi_o = line_mesi_i[victim_way_o];
    end

endmodule

`default_nettype wire
